// ==== logic/ddr_geom_pkg.sv ====
package ddr_geom_pkg;

    // Data word and byte lanes
    localparam int WORD_W = 64;
    localparam int BE_W   = WORD_W / 8;

    // Full command address, as seen on the master bus
    localparam int ADDR_W = 29;

    // Burst length field
    localparam int BURST_W = 8;

    // Cycles from command acceptance to the last wait cycle before data
    localparam int READ_LAT = 7;

    // Length of one refresh slot
    localparam int RFSH_CYCLES = 4;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BE_W-1:0]    be_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [BURST_W-1:0] burst_t;

endpackage

// ==== logic/ddr_bus_pkg.sv ====
package ddr_bus_pkg;

    // One command from the master
    // For a write burst, wdata and be carry the current beat
    typedef struct packed {
        logic                 valid;
        // 1 = read, 0 = write
        logic                 rd;
        ddr_geom_pkg::addr_t  addr;
        // 0 is taken as a single beat
        ddr_geom_pkg::burst_t burst;
        ddr_geom_pkg::word_t  wdata;
        ddr_geom_pkg::be_t    be;
    } ddr_cmd_t;

    // Read data returned to the master, one word per cycle
    typedef struct packed {
        logic                valid;
        ddr_geom_pkg::word_t rdata;
    } ddr_rsp_t;

endpackage

// ==== logic/frac_cen.sv ====
`timescale 1ns/1ns

module frac_cen #(
    parameter int N  = 1,
    parameter int M  = 64,
    parameter int WC = 8
) (
    input  logic clk,
    input  logic arst_n,
    output logic cen
);

    localparam logic [WC:0] STEP = (WC+1)'(N);
    localparam logic [WC:0] WRAP = (WC+1)'(M);

    logic [WC-1:0] acc;
    logic [WC:0]   sum;

    // One extra bit so the sum never overflows before the compare
    assign sum = {1'b0, acc} + STEP;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (sum >= WRAP) begin
            // Overflow gives one enable pulse
            acc <= WC'(sum - WRAP);
            cen <= 1'b1;
        end else begin
            acc <= sum[WC-1:0];
            cen <= 1'b0;
        end
    end

endmodule

// ==== logic/burst_mem_array.sv ====
`timescale 1ns/1ns

module burst_mem_array #(
    parameter int MEM_AW = 10
) (
    input  logic                clk,
    input  logic [MEM_AW-1:0]   addr,
    input  logic                we,
    input  ddr_geom_pkg::be_t   be,
    input  ddr_geom_pkg::word_t wdata,
    output ddr_geom_pkg::word_t rdata
);

    localparam int DEPTH = 2 ** MEM_AW;

    // Starts out cleared
    ddr_geom_pkg::word_t mem [DEPTH] = '{default: '0};

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < ddr_geom_pkg::BE_W; b++) begin
                if (be[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Unregistered read, timing comes from the address register upstream
    assign rdata = mem[addr];

endmodule

// ==== logic/burst_ctrl.sv ====
`timescale 1ns/1ns

module burst_ctrl #(
    parameter int MEM_AW = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  prog_en,
    input  logic                  rfsh_cen,
    input  ddr_bus_pkg::ddr_cmd_t cmd,
    output logic                  busy,
    output logic                  rsp_valid,
    output logic [MEM_AW-1:0]     mem_addr,
    output logic                  mem_we,
    output ddr_geom_pkg::be_t     mem_be,
    output ddr_geom_pkg::word_t   mem_wdata
);

    localparam int LAT_W = $clog2(ddr_geom_pkg::READ_LAT + 1);
    localparam int RC_W  = $clog2(ddr_geom_pkg::RFSH_CYCLES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RFSH,
        ST_WRITE,
        ST_READ
    } state_t;

    state_t               state;
    ddr_geom_pkg::burst_t beat_cnt;
    ddr_geom_pkg::burst_t burst_len;
    logic [MEM_AW-1:0]    addr_r;
    logic [LAT_W-1:0]     lat_cnt;
    logic [RC_W-1:0]      rfsh_cnt;
    logic                 rfsh_pend;
    logic                 rfsh_done;
    logic                 accept;

    // A pending refresh already blocks new commands
    assign busy   = (state != ST_IDLE) || rfsh_pend;
    assign accept = cmd.valid && !busy;

    assign burst_len = (cmd.burst == '0) ? ddr_geom_pkg::burst_t'(1) : cmd.burst;
    assign rfsh_done = (state == ST_RFSH) && (rfsh_cnt == '0);

    // Beat 0 of a write goes straight through while idle
    assign mem_addr  = (state == ST_IDLE) ? cmd.addr[MEM_AW-1:0] : addr_r;
    assign mem_we    = (state == ST_WRITE) ? (beat_cnt != '0) : (accept && !cmd.rd);
    assign mem_be    = cmd.be;
    assign mem_wdata = cmd.wdata;

    // Pacer pulses are dropped while a ROM download runs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rfsh_pend <= 1'b0;
        end else begin
            rfsh_pend <= (rfsh_pend && !rfsh_done) || (rfsh_cen && !prog_en);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            beat_cnt  <= '0;
            addr_r    <= '0;
            lat_cnt   <= '0;
            rfsh_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rfsh_pend) begin
                        // The idle cycle with the flag set counts as the first slot cycle
                        rfsh_cnt <= RC_W'(ddr_geom_pkg::RFSH_CYCLES - 2);
                        state    <= ST_RFSH;
                    end else if (accept && cmd.rd) begin
                        addr_r   <= cmd.addr[MEM_AW-1:0];
                        beat_cnt <= burst_len;
                        lat_cnt  <= LAT_W'(ddr_geom_pkg::READ_LAT);
                        state    <= ST_READ;
                    end else if (accept) begin
                        addr_r   <= cmd.addr[MEM_AW-1:0] + 1'b1;
                        beat_cnt <= burst_len - 1'b1;
                        state    <= ST_WRITE;
                    end
                end
                ST_RFSH: begin
                    if (rfsh_cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        rfsh_cnt <= rfsh_cnt - 1'b1;
                    end
                end
                ST_WRITE: begin
                    // Beats left after the one taken at acceptance
                    if (beat_cnt != '0) begin
                        addr_r   <= addr_r + 1'b1;
                        beat_cnt <= beat_cnt - 1'b1;
                    end
                    if (beat_cnt <= ddr_geom_pkg::burst_t'(1)) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 1'b1;
                        if (lat_cnt == LAT_W'(1)) begin
                            rsp_valid <= 1'b1;
                        end
                    end else begin
                        // Streaming, one word per cycle
                        addr_r   <= addr_r + 1'b1;
                        beat_cnt <= beat_cnt - 1'b1;
                        if (beat_cnt == ddr_geom_pkg::burst_t'(1)) begin
                            rsp_valid <= 1'b0;
                            state     <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/ddr_sim_top.sv ====
`timescale 1ns/1ns

module ddr_sim_top #(
    parameter int MEM_AW  = 10,
    parameter int RFSH_N  = 1,
    parameter int RFSH_M  = 64,
    parameter int RFSH_WC = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  prog_en,
    input  ddr_bus_pkg::ddr_cmd_t cmd,
    output logic                  busy,
    output ddr_bus_pkg::ddr_rsp_t rsp
);

    logic                rfsh_cen;
    logic [MEM_AW-1:0]   mem_addr;
    logic                mem_we;
    ddr_geom_pkg::be_t   mem_be;
    ddr_geom_pkg::word_t mem_wdata;

    // Refresh slot pacing
    frac_cen #(
        .N  (RFSH_N),
        .M  (RFSH_M),
        .WC (RFSH_WC)
    ) i_frac_cen (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (rfsh_cen)
    );

    burst_ctrl #(
        .MEM_AW (MEM_AW)
    ) i_burst_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_en   (prog_en),
        .rfsh_cen  (rfsh_cen),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp.valid),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_wdata (mem_wdata)
    );

    // Read word goes straight onto the response bus
    burst_mem_array #(
        .MEM_AW (MEM_AW)
    ) i_burst_mem_array (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .be    (mem_be),
        .wdata (mem_wdata),
        .rdata (rsp.rdata)
    );

endmodule

// ==== dv/ddr_ref_model.svh ====
`ifndef DDR_REF_MODEL_SVH
`define DDR_REF_MODEL_SVH

// Mirror of the DUT storage, indexed by the stored address bits only
ddr_geom_pkg::word_t model_mem [2**MEM_AW] = '{default: '0};
int check_cnt = 0;
int err_cnt   = 0;

// Upper command address bits are dropped, bursts wrap at the top
function automatic int model_index(input ddr_geom_pkg::addr_t addr, input int beat);
    return (int'(addr[MEM_AW-1:0]) + beat) % (2 ** MEM_AW);
endfunction

task automatic model_write(input ddr_geom_pkg::addr_t addr, input int beat,
                           input ddr_geom_pkg::word_t wdata, input ddr_geom_pkg::be_t be);
    int idx;
    idx = model_index(addr, beat);
    for (int b = 0; b < ddr_geom_pkg::BE_W; b++) begin
        if (be[b]) begin
            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
        end
    end
endtask

function automatic ddr_geom_pkg::word_t model_read(input ddr_geom_pkg::addr_t addr,
                                                   input int beat);
    return model_mem[model_index(addr, beat)];
endfunction

task automatic compare_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_cnt++;
    if (expected !== actual) begin
        err_cnt++;
        $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    err_cnt++;
    $display("[ERROR] %s", msg);
endtask

`endif

// ==== dv/tb_ddr_sim_top.sv ====
`timescale 1ns/1ns

module tb_ddr_sim_top;

    localparam int MEM_AW      = 10;
    localparam int RFSH_N      = 1;
    localparam int RFSH_M      = 64;
    localparam int RFSH_WC     = 8;
    localparam int LAT         = ddr_geom_pkg::READ_LAT;
    localparam int RFSH_LEN    = ddr_geom_pkg::RFSH_CYCLES;
    localparam int MAX_BURST   = 16;
    localparam int BURST_COUNT = 34;
    localparam int WINDOW      = 4 * RFSH_M;
    // Worst case of all bursts and both refresh windows times two
    localparam int TIMEOUT_CYC = 2 * (BURST_COUNT * (MAX_BURST + LAT + RFSH_LEN + 4)
                                      + 2 * (WINDOW + 4 * RFSH_LEN) + 20);

    logic                  clk;
    logic                  arst_n;
    logic                  prog_en;
    ddr_bus_pkg::ddr_cmd_t cmd;
    logic                  busy;
    ddr_bus_pkg::ddr_rsp_t rsp;
    integer                seed;
    int                    cyc_cnt = 0;
    int                    test_cnt = 0;
    int                    test_err = 0;
    ddr_geom_pkg::addr_t   base_q[$];
    ddr_geom_pkg::burst_t  burst_q[$];

    `include "ddr_ref_model.svh"

    ddr_sim_top #(
        .MEM_AW  (MEM_AW),
        .RFSH_N  (RFSH_N),
        .RFSH_M  (RFSH_M),
        .RFSH_WC (RFSH_WC)
    ) i_ddr_sim_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .prog_en (prog_en),
        .cmd     (cmd),
        .busy    (busy),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("[ERROR] run stopped after %0d cycles without reaching the end", cyc_cnt);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic int beats_of(input ddr_geom_pkg::burst_t burst);
        return (burst == '0) ? 1 : int'(burst);
    endfunction

    // Inputs move 1 ns after the edge so busy and rsp are settled here
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            taken = !busy;
            step();
        end
    endtask

    task automatic write_burst(input ddr_geom_pkg::addr_t addr,
                               input ddr_geom_pkg::burst_t burst, input logic full_be);
        int len;
        len       = beats_of(burst);
        cmd.valid = 1'b1;
        cmd.rd    = 1'b0;
        cmd.addr  = addr;
        cmd.burst = burst;
        for (int k = 0; k < len; k++) begin
            cmd.wdata = {next_rand(), next_rand()};
            cmd.be    = full_be ? '1 : ddr_geom_pkg::be_t'(next_rand());
            model_write(addr, k, cmd.wdata, cmd.be);
            if (k == 0) begin
                wait_accept();
                cmd.valid = 1'b0;
            end else begin
                step();
            end
        end
    endtask

    task automatic read_burst(input string name, input ddr_geom_pkg::addr_t addr,
                              input ddr_geom_pkg::burst_t burst);
        int   len;
        int   cyc;
        int   first;
        int   beats;
        logic done;
        len       = beats_of(burst);
        cmd.valid = 1'b1;
        cmd.rd    = 1'b1;
        cmd.addr  = addr;
        cmd.burst = burst;
        wait_accept();
        cmd.valid = 1'b0;
        cyc   = 0;
        first = -1;
        beats = 0;
        done  = 1'b0;
        // cyc counts edges after acceptance
        while (!done) begin
            cyc++;
            if (rsp.valid) begin
                if (first < 0) begin
                    first = cyc;
                end
                compare_val(name, model_read(addr, beats), rsp.rdata);
                beats++;
                done = (beats == len);
            end else begin
                done = (first >= 0) || (cyc > LAT + len + 4);
            end
            step();
        end
        if (beats != len) begin
            report_error($sformatf("%s returned %0d beats where %0d were due", name, beats, len));
        end
        compare_val({name, " first beat cycle"}, 64'(LAT + 1), 64'(first));
        compare_val({name, " valid after last beat"}, 64'(0), 64'(rsp.valid));
    endtask

    task automatic check_refresh(input string name, input logic prog, input int nominal,
                                 input int tol);
        int   rises;
        int   run_len;
        logic in_rise;
        prog_en = prog;
        // Let a slot that was already pending run out
        repeat (RFSH_LEN + 2) step();
        while (busy) begin
            step();
        end
        rises   = 0;
        run_len = 0;
        in_rise = 1'b0;
        for (int i = 0; i < WINDOW; i++) begin
            if (busy) begin
                if (!in_rise) begin
                    rises++;
                    run_len = 0;
                end
                in_rise = 1'b1;
                run_len++;
            end else if (in_rise) begin
                compare_val({name, " busy length"}, 64'(RFSH_LEN), 64'(run_len));
                in_rise = 1'b0;
            end
            step();
        end
        while (in_rise) begin
            if (busy) begin
                run_len++;
            end else begin
                compare_val({name, " busy length"}, 64'(RFSH_LEN), 64'(run_len));
                in_rise = 1'b0;
            end
            step();
        end
        // Rise count may drift by tol around the nominal count
        if (rises < nominal - tol || rises > nominal + tol) begin
            compare_val({name, " busy rises"}, 64'(nominal), 64'(rises));
        end
        prog_en = 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("[TEST] %s finished with %0d errors", name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    initial begin
        ddr_geom_pkg::addr_t  base;
        ddr_geom_pkg::burst_t burst;
        seed    = 32'hce68_61a2;
        arst_n  = 1'b1;
        prog_en = 1'b0;
        cmd     = '0;
        #2;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Nothing pending before the first pacer pulse
        compare_val("reset busy", 64'(0), 64'(busy));
        compare_val("reset rsp.valid", 64'(0), 64'(rsp.valid));
        read_burst("reset read", ddr_geom_pkg::addr_t'(next_rand()), ddr_geom_pkg::burst_t'(4));
        finish_test("reset_state");

        for (int i = 0; i < 6; i++) begin
            base  = ddr_geom_pkg::addr_t'(next_rand() % 32'd1008);
            burst = ddr_geom_pkg::burst_t'(32'd1 + next_rand() % 32'd16);
            base_q.push_back(base);
            burst_q.push_back(burst);
            write_burst(base, burst, 1'b1);
            read_burst("full write read", base, burst);
        end
        finish_test("full_write_read");

        // Partial lanes over the words written above
        for (int i = 0; i < 6; i++) begin
            write_burst(base_q[i], burst_q[i], 1'b0);
            read_burst("byte enable", base_q[i], burst_q[i]);
        end
        finish_test("byte_enable");

        read_burst("read timing", ddr_geom_pkg::addr_t'(next_rand()), ddr_geom_pkg::burst_t'(0));
        read_burst("read timing", ddr_geom_pkg::addr_t'(next_rand()), ddr_geom_pkg::burst_t'(1));
        for (int i = 0; i < 4; i++) begin
            burst = ddr_geom_pkg::burst_t'(32'd2 + next_rand() % 32'd15);
            read_burst("read timing", ddr_geom_pkg::addr_t'(next_rand()), burst);
        end
        finish_test("read_timing");

        check_refresh("refresh prog", 1'b1, 0, 0);
        check_refresh("refresh run", 1'b0, RFSH_N * 4, 1);
        finish_test("refresh_gating");

        // Start four words below the top with random upper bits
        base = (ddr_geom_pkg::addr_t'(next_rand()) << MEM_AW)
               | ddr_geom_pkg::addr_t'(2**MEM_AW - 4);
        write_burst(base, ddr_geom_pkg::burst_t'(8), 1'b1);
        base = (ddr_geom_pkg::addr_t'(next_rand()) << MEM_AW)
               | ddr_geom_pkg::addr_t'(2**MEM_AW - 4);
        read_burst("addr wrap", base, ddr_geom_pkg::burst_t'(8));
        read_burst("addr wrap low", ddr_geom_pkg::addr_t'(next_rand()) << MEM_AW,
                   ddr_geom_pkg::burst_t'(4));
        finish_test("addr_wrap");

        $display("[DONE] %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== ddr_sim.f ====
+incdir+dv
logic/ddr_geom_pkg.sv
logic/ddr_bus_pkg.sv
logic/frac_cen.sv
logic/burst_mem_array.sv
logic/burst_ctrl.sv
logic/ddr_sim_top.sv
dv/tb_ddr_sim_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the burst memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f ddr_sim.f --top-module tb_ddr_sim_top
./obj_dir/Vtb_ddr_sim_top > sim.log 2>&1
cat sim.log

# The log decides the result
if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
